//--- hdl/alu_consts.svh
////////////////////////////////////////
// Widths and codes of the integer element
// Instruction bits not listed here are ignored
// Opcodes 8 to 15 produce a zero result
////////////////////////////////////////
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_WIDTH_DATA		32
`define ALU_WIDTH_OPCODE	4
`define ALU_WIDTH_SRCSEL	2
`define ALU_WIDTH_IMM		8
`define ALU_WIDTH_SHAMT		5
`define ALU_NUM_SRC			3

// Instruction field positions
`define ALU_OPCODE_MSB		3
`define ALU_OPCODE_LSB		0
`define ALU_SRCSEL_MSB		5
`define ALU_SRCSEL_LSB		4
`define ALU_IMM_MSB			15
`define ALU_IMM_LSB			8

`define ALU_OP_ADD			4'd0
`define ALU_OP_SUB			4'd1
`define ALU_OP_AND			4'd2
`define ALU_OP_OR			4'd3
`define ALU_OP_XOR			4'd4
`define ALU_OP_SHL			4'd5
`define ALU_OP_SHR			4'd6
`define ALU_OP_ROL			4'd7

// Source pairs, first op second
`define ALU_SRC_AB			2'd0
`define ALU_SRC_BA			2'd1
`define ALU_SRC_AC			2'd2
`define ALU_SRC_AI			2'd3

`endif

//--- hdl/aluPkg.sv
////////////////////////////////////////
// Types shared by the element and its testbench
// Widths are taken from alu_consts.svh
////////////////////////////////////////
`include "alu_consts.svh"

package aluPkg;

	typedef logic [`ALU_WIDTH_DATA-1:0]		wordT;
	typedef logic [`ALU_WIDTH_OPCODE-1:0]	opcodeT;
	typedef logic [`ALU_WIDTH_SRCSEL-1:0]	srcSelT;
	typedef logic [`ALU_WIDTH_IMM-1:0]		immT;

	////////////////////////////////////////
	// Data token on a source or result port
	////////////////////////////////////////
	typedef struct packed {
		logic	valid;
		logic	last;
		wordT	data;
	} tokenT;

	////////////////////////////////////////
	// Decoded configuration
	////////////////////////////////////////
	// enSrc bit 0 is A, bit 1 is B, bit 2 is C
	typedef struct packed {
		logic						active;
		opcodeT						opcode;
		srcSelT						srcSel;
		logic [`ALU_NUM_SRC-1:0]	enSrc;
		immT						imm;
	} ctrlT;

endpackage

//--- hdl/aluConfig.sv
////////////////////////////////////////
// Instruction register and configured flag
// A strobe is taken only while not configured
// Configuration is dropped on a last result
////////////////////////////////////////
`timescale 1ns/100ps
`include "alu_consts.svh"

module aluConfig (
	input	logic			clock,
	input	logic			reset,
	input	logic			configStrobe,
	input	aluPkg::wordT	configWord,
	input	logic			releaseConfig,
	output	aluPkg::ctrlT	ctrl
);

	aluPkg::opcodeT		opcodeReg;
	aluPkg::srcSelT		srcSelReg;
	aluPkg::immT		immReg;

	logic				configured;
	logic				accept;
	logic				enableB;
	logic				enableC;

	// Strobes while busy are dropped
	assign accept = configStrobe & ~configured;

	////////////////////////////////////////
	// Instruction register
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (accept) begin
			opcodeReg	<= configWord[`ALU_OPCODE_MSB:`ALU_OPCODE_LSB];
			srcSelReg	<= configWord[`ALU_SRCSEL_MSB:`ALU_SRCSEL_LSB];
			immReg		<= configWord[`ALU_IMM_MSB:`ALU_IMM_LSB];
		end
	end

	// Configured flag
	always_ff @(posedge clock) begin
		if (reset) begin
			configured <= 1'b0;
		end else if (accept) begin
			configured <= 1'b1;
		end else if (releaseConfig) begin
			configured <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Decode to datapath controls
	////////////////////////////////////////
	// B feeds both orderings, C only the AC pair
	assign enableB = (srcSelReg == `ALU_SRC_AB) | (srcSelReg == `ALU_SRC_BA);
	assign enableC = (srcSelReg == `ALU_SRC_AC);

	always_comb begin
		ctrl.active		= configured;
		ctrl.opcode		= opcodeReg;
		ctrl.srcSel		= srcSelReg;
		ctrl.imm		= immReg;
		ctrl.enSrc[0]	= 1'b1;
		ctrl.enSrc[1]	= enableB;
		ctrl.enSrc[2]	= enableC;
	end

endmodule

//--- hdl/aluDatapath.sv
////////////////////////////////////////
// Operand join, integer operations, result register
// Sources are not buffered; all enabled tokens
// must be valid in the same cycle to fire
// The result sink never stalls
////////////////////////////////////////
`timescale 1ns/100ps
`include "alu_consts.svh"

module aluDatapath (
	input	logic			clock,
	input	logic			reset,
	input	aluPkg::ctrlT	ctrl,
	input	aluPkg::tokenT	operandA,
	input	aluPkg::tokenT	operandB,
	input	aluPkg::tokenT	operandC,
	output	aluPkg::tokenT	result,
	output	logic			releaseConfig
);

	aluPkg::wordT					firstOperand;
	aluPkg::wordT					secondOperand;
	aluPkg::wordT					immExtended;
	aluPkg::wordT					opResult;
	logic [`ALU_WIDTH_SHAMT-1:0]	shiftAmount;
	logic [2*`ALU_WIDTH_DATA-1:0]	rotateWide;
	logic							fire;
	logic							lastAny;

	////////////////////////////////////////
	// Join
	////////////////////////////////////////
	// A disabled source never holds the group back
	assign fire = ctrl.active
		& (operandA.valid | ~ctrl.enSrc[0])
		& (operandB.valid | ~ctrl.enSrc[1])
		& (operandC.valid | ~ctrl.enSrc[2]);

	assign lastAny = (ctrl.enSrc[0] & operandA.last)
		| (ctrl.enSrc[1] & operandB.last)
		| (ctrl.enSrc[2] & operandC.last);

	////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////
	assign immExtended = {{(`ALU_WIDTH_DATA-`ALU_WIDTH_IMM){1'b0}}, ctrl.imm};

	always_comb begin
		firstOperand	= operandA.data;
		secondOperand	= operandB.data;
		case (ctrl.srcSel)
			`ALU_SRC_AB: begin
				firstOperand	= operandA.data;
				secondOperand	= operandB.data;
			end
			`ALU_SRC_BA: begin
				firstOperand	= operandB.data;
				secondOperand	= operandA.data;
			end
			`ALU_SRC_AC: begin
				firstOperand	= operandA.data;
				secondOperand	= operandC.data;
			end
			`ALU_SRC_AI: begin
				firstOperand	= operandA.data;
				secondOperand	= immExtended;
			end
		endcase
	end

	////////////////////////////////////////
	// Operations
	////////////////////////////////////////
	assign shiftAmount = secondOperand[`ALU_WIDTH_SHAMT-1:0];

	// Upper half of the doubled word is the rotated value
	assign rotateWide = {firstOperand, firstOperand} << shiftAmount;

	always_comb begin
		case (ctrl.opcode)
			`ALU_OP_ADD:	opResult = firstOperand + secondOperand;
			`ALU_OP_SUB:	opResult = firstOperand - secondOperand;
			`ALU_OP_AND:	opResult = firstOperand & secondOperand;
			`ALU_OP_OR:		opResult = firstOperand | secondOperand;
			`ALU_OP_XOR:	opResult = firstOperand ^ secondOperand;
			`ALU_OP_SHL:	opResult = firstOperand << shiftAmount;
			`ALU_OP_SHR:	opResult = firstOperand >> shiftAmount;
			`ALU_OP_ROL:	opResult = rotateWide[2*`ALU_WIDTH_DATA-1:`ALU_WIDTH_DATA];
			default:		opResult = '0;
		endcase
	end

	////////////////////////////////////////
	// Result token
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid	<= 1'b0;
			result.last		<= 1'b0;
			result.data		<= '0;
		end else begin
			result.valid	<= fire;
			result.last		<= fire & lastAny;
			if (fire) begin
				result.data	<= opResult;
			end
		end
	end

	// Drops the configuration at the edge that loads the last result
	assign releaseConfig = fire & lastAny;

endmodule

//--- hdl/aluTop.sv
////////////////////////////////////////
// Integer arithmetic element, top level
// One instruction per configuration; busy stays
// high until a result with last is produced
////////////////////////////////////////
`timescale 1ns/100ps

module aluTop (
	input	logic			clock,
	input	logic			reset,
	input	logic			configStrobe,
	input	aluPkg::wordT	configWord,
	input	aluPkg::tokenT	operandA,
	input	aluPkg::tokenT	operandB,
	input	aluPkg::tokenT	operandC,
	output	aluPkg::tokenT	result,
	output	logic			busy
);

	aluPkg::ctrlT	ctrl;
	logic			releaseConfig;

	////////////////////////////////////////
	// Configuration
	////////////////////////////////////////
	aluConfig u_aluConfig (
		.clock			(clock),
		.reset			(reset),
		.configStrobe	(configStrobe),
		.configWord		(configWord),
		.releaseConfig	(releaseConfig),
		.ctrl			(ctrl)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////
	aluDatapath u_aluDatapath (
		.clock			(clock),
		.reset			(reset),
		.ctrl			(ctrl),
		.operandA		(operandA),
		.operandB		(operandB),
		.operandC		(operandC),
		.result			(result),
		.releaseConfig	(releaseConfig)
	);

	assign busy = ctrl.active;

endmodule

//--- tests/aluTopTb.sv
////////////////////////////////////////
// Testbench for the integer element
// Operand data comes from a fixed-seed xorshift
// Every table row that configures must end with
// a last token, so the next row can configure
////////////////////////////////////////
`timescale 1ns/100ps
`include "alu_consts.svh"

module aluTopTb;

	typedef struct packed {
		logic			sendConfig;
		logic			strayStrobe;
		aluPkg::wordT	instr;
		logic [3:0]		groupCount;
		logic [7:0]		validA;
		logic [7:0]		validB;
		logic [7:0]		validC;
		logic [7:0]		lastA;
		logic [7:0]		lastB;
		logic [7:0]		lastC;
	} rowT;

	logic			clock;
	logic			reset;
	logic			configStrobe;
	aluPkg::wordT	configWord;
	aluPkg::tokenT	operandA;
	aluPkg::tokenT	operandB;
	aluPkg::tokenT	operandC;
	aluPkg::tokenT	result;
	logic			busy;

	rowT			testRows[$];
	logic [31:0]	randState;
	logic			modelBusy;
	aluPkg::wordT	modelInstr;
	aluPkg::wordT	strayInstr;
	int				valueErrors;
	int				protocolErrors;
	time			timeLimit;

	aluTop u_aluTop (
		.clock			(clock),
		.reset			(reset),
		.configStrobe	(configStrobe),
		.configWord		(configWord),
		.operandA		(operandA),
		.operandB		(operandB),
		.operandC		(operandC),
		.result			(result),
		.busy			(busy)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = randState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		randState = x;
		return x;
	endfunction

	// Upper bits and bits 7:6 carry junk that must be ignored
	function automatic aluPkg::wordT makeInstr(input aluPkg::opcodeT op,
		input aluPkg::srcSelT src, input aluPkg::immT imm);
		return {16'h5a3c, imm, 2'b11, src, op};
	endfunction

	function automatic aluPkg::tokenT makeToken(input logic valid, input logic last,
		input aluPkg::wordT data);
		aluPkg::tokenT token;
		token.valid = valid;
		token.last = last;
		token.data = data;
		return token;
	endfunction

	// Expected value from the instruction rules
	function automatic aluPkg::wordT referenceResult(input aluPkg::wordT instr,
		input aluPkg::wordT a, input aluPkg::wordT b, input aluPkg::wordT c);
		aluPkg::wordT x;
		aluPkg::wordT y;
		int unsigned n;
		case (instr[`ALU_SRCSEL_MSB:`ALU_SRCSEL_LSB])
			`ALU_SRC_AB: begin
				x = a;
				y = b;
			end
			`ALU_SRC_BA: begin
				x = b;
				y = a;
			end
			`ALU_SRC_AC: begin
				x = a;
				y = c;
			end
			default: begin
				x = a;
				y = instr[`ALU_IMM_MSB:`ALU_IMM_LSB];
			end
		endcase
		n = y & 32'd31;
		case (instr[`ALU_OPCODE_MSB:`ALU_OPCODE_LSB])
			`ALU_OP_ADD: referenceResult = x + y;
			`ALU_OP_SUB: referenceResult = x + ~y + 32'd1;
			`ALU_OP_AND: referenceResult = x & y;
			`ALU_OP_OR:  referenceResult = x | y;
			`ALU_OP_XOR: referenceResult = x ^ y;
			`ALU_OP_SHL: referenceResult = x << n;
			`ALU_OP_SHR: referenceResult = x >> n;
			`ALU_OP_ROL: referenceResult = (n == 0) ? x : ((x << n) | (x >> (32 - n)));
			default:     referenceResult = '0;
		endcase
	endfunction

	task automatic addRow(input logic sendConfig, input logic strayStrobe,
		input aluPkg::wordT instr, input logic [3:0] groupCount,
		input logic [7:0] validA, input logic [7:0] validB, input logic [7:0] validC,
		input logic [7:0] lastA, input logic [7:0] lastB, input logic [7:0] lastC);
		testRows.push_back({sendConfig, strayStrobe, instr, groupCount,
			validA, validB, validC, lastA, lastB, lastC});
	endtask

	task automatic nextCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic checkWord(input string name, input aluPkg::wordT expected,
		input aluPkg::wordT actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED at %0t: %s expected %h, actual %h",
				$time, name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED at %0t: %s expected %b, actual %b",
				$time, name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkPulse(input logic expected);
		if (expected) begin
			assert (result.valid === 1'b1) else begin
				$display("Missing result pulse at %0t", $time);
				protocolErrors++;
			end
		end else begin
			assert (result.valid === 1'b0) else begin
				$display("Unexpected result pulse at %0t", $time);
				protocolErrors++;
			end
		end
	endtask

	////////////////////////////////////////
	// One table row
	////////////////////////////////////////
	task automatic runRow(input rowT row);
		aluPkg::wordT	a;
		aluPkg::wordT	b;
		aluPkg::wordT	c;
		aluPkg::srcSelT	src;
		logic			enB;
		logic			enC;
		logic			fire;
		logic			lastOut;
		logic			strayTaken;
		int				g;
		if (row.sendConfig) begin
			configStrobe = 1'b1;
			configWord = row.instr;
			if (!modelBusy) begin
				modelBusy = 1'b1;
				modelInstr = row.instr;
			end
			nextCycle();
			configStrobe = 1'b0;
			configWord = '0;
			checkPulse(1'b0);
			checkBit("busy", modelBusy, busy);
		end
		for (g = 0; g < row.groupCount; g++) begin
			a = nextRandom();
			b = nextRandom();
			c = nextRandom();
			operandA = makeToken(row.validA[g], row.lastA[g], a);
			operandB = makeToken(row.validB[g], row.lastB[g], b);
			operandC = makeToken(row.validC[g], row.lastC[g], c);
			strayTaken = 1'b0;
			if (row.strayStrobe && g == 0) begin
				configStrobe = 1'b1;
				configWord = strayInstr;
				strayTaken = !modelBusy;
			end
			src = modelInstr[`ALU_SRCSEL_MSB:`ALU_SRCSEL_LSB];
			enB = (src == `ALU_SRC_AB) || (src == `ALU_SRC_BA);
			enC = (src == `ALU_SRC_AC);
			fire = modelBusy && row.validA[g] && (!enB || row.validB[g])
				&& (!enC || row.validC[g]);
			lastOut = row.lastA[g] | (enB & row.lastB[g]) | (enC & row.lastC[g]);
			nextCycle();
			configStrobe = 1'b0;
			configWord = '0;
			operandA = '0;
			operandB = '0;
			operandC = '0;
			checkPulse(fire);
			if (fire) begin
				checkWord("result.data", referenceResult(modelInstr, a, b, c), result.data);
				checkBit("result.last", lastOut, result.last);
			end
			if (fire && lastOut) begin
				modelBusy = 1'b0;
			end
			if (strayTaken) begin
				modelBusy = 1'b1;
				modelInstr = strayInstr;
			end
			checkBit("busy", modelBusy, busy);
		end
		nextCycle();
		checkPulse(1'b0);
		checkBit("busy", modelBusy, busy);
	endtask

	task automatic loadTable();
		// Tokens before any configuration
		addRow(1'b0, 1'b0, makeInstr(`ALU_OP_ADD, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h07, 8'h04, 8'h00, 8'h00);
		// Every opcode under AB, back to back
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_ADD, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h04, 8'h00, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_SUB, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h00, 8'h04, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_AND, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h04, 8'h00, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_OR, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h00, 8'h04, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_XOR, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h04, 8'h00, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_SHL, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h04, 8'h00, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_SHR, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h00, 8'h04, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_ROL, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h04, 8'h00, 8'h00);
		// B missing in group 1, whose last on A must not release
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_SUB, `ALU_SRC_AB, 8'h00), 4'd4,
			8'h0f, 8'h0d, 8'h00, 8'h02, 8'h08, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_SUB, `ALU_SRC_BA, 8'h00), 4'd2,
			8'h03, 8'h03, 8'h00, 8'h00, 8'h02, 8'h00);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_SHR, `ALU_SRC_AC, 8'h00), 4'd3,
			8'h07, 8'h02, 8'h05, 8'h00, 8'h02, 8'h04);
		// Immediate with bit 7 set; B and C tokens ignored
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_ADD, `ALU_SRC_AI, 8'ha5), 4'd4,
			8'h0d, 8'h0f, 8'h0f, 8'h08, 8'h04, 8'h02);
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_ROL, `ALU_SRC_AI, 8'he3), 4'd2,
			8'h03, 8'h00, 8'h00, 8'h02, 8'h00, 8'h00);
		// Groups after the release must stay silent
		addRow(1'b1, 1'b0, makeInstr(`ALU_OP_XOR, `ALU_SRC_AB, 8'h00), 4'd4,
			8'h0f, 8'h0f, 8'h00, 8'h02, 8'h00, 8'h00);
		addRow(1'b1, 1'b1, makeInstr(`ALU_OP_ADD, `ALU_SRC_AB, 8'h00), 4'd3,
			8'h07, 8'h07, 8'h00, 8'h04, 8'h00, 8'h00);
		// Undefined opcode gives zero
		addRow(1'b1, 1'b0, makeInstr(4'd9, `ALU_SRC_AB, 8'h00), 4'd2,
			8'h03, 8'h03, 8'h00, 8'h02, 8'h00, 8'h00);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		reset = 1'b1;
		configStrobe = 1'b0;
		configWord = '0;
		operandA = '0;
		operandB = '0;
		operandC = '0;
		randState = 32'heea4d393;
		modelBusy = 1'b0;
		modelInstr = '0;
		strayInstr = makeInstr(`ALU_OP_SUB, `ALU_SRC_BA, 8'h11);
		valueErrors = 0;
		protocolErrors = 0;
		loadTable();
		timeLimit = 10 * 40;
		for (int i = 0; i < testRows.size(); i++) begin
			timeLimit += 40 * (testRows[i].groupCount + 4);
		end

		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		checkBit("busy", 1'b0, busy);
		checkPulse(1'b0);
		checkBit("result.last", 1'b0, result.last);
		checkWord("result.data", '0, result.data);

		for (int i = 0; i < testRows.size(); i++) begin
			runRow(testRows[i]);
		end

		$display("Value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (timeLimit != 0);
		#(timeLimit);
		$display("Timeout: the tests did not finish within %0t", timeLimit);
		$display("Errors found");
		$finish;
	end

endmodule

//--- aluTop.f
+incdir+hdl
hdl/aluPkg.sv
hdl/aluConfig.sv
hdl/aluDatapath.sv
hdl/aluTop.sv
tests/aluTopTb.sv

//--- Makefile
# Verilator build and run of the integer element testbench
TOP = aluTopTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f aluTop.f -Mdir obj_dir

# Fails when the log holds the fail message
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@! grep -q "Errors found" sim.log

clean:
	rm -rf obj_dir sim.log
